// File: project.f
camera_pkg.sv
pixel_window.sv
buffer_bank.sv
command_port.sv
camera_top.sv
camera_sva.sv
tb_camera.sv

// File: run.sh
#!/bin/sh
# Build and run the camera capture testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_camera \
    --Mdir obj_dir -o sim_camera \
    -f project.f

./obj_dir/sim_camera 2>&1 | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "run.sh: simulation reported failure"
    exit 1
fi

if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "run.sh: simulation ended without a result"
    exit 1
fi

echo "run.sh: simulation passed"

// File: tb_camera.sv
`default_nettype none

module tb_camera import camera_pkg::*;;

    localparam int FRAME_LINES    = 14;
    localparam int LINE_PIXELS    = 28;
    localparam int LINE_GAP       = 3;
    // Three frames of 440 cycles and three buffer reads of about 520 cycles,
    // so roughly 3000 cycles in all, with ample margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic        clock_byte = 1'b0;
    logic        reset_sync_n;
    logic        frame_valid_i;
    logic        line_valid_i;
    pixel_raw_t  pixel_data_i;
    op_code_t    op_code_i;
    logic        op_code_valid_i;
    logic        operand_valid_i;
    logic [7:0]  operand_index_i;
    pixel_byte_t response_o;
    logic        response_valid_o;

    logic [31:0] lfsr_state;
    pixel_byte_t frame_model [CAPTURE_BYTES];    // Window of the last frame sent
    pixel_byte_t buffer_model [CAPTURE_BYTES];   // What the buffer should hold
    int          error_count;
    int          test_count;
    int          failed_tests;
    int          errors_at_test_start;
    int          cycle_count;
    string       test_name;

    camera_top UUT (
        .clock_byte        (clock_byte),
        .reset_sync_n      (reset_sync_n),
        .frame_valid_i     (frame_valid_i),
        .line_valid_i      (line_valid_i),
        .pixel_data_i      (pixel_data_i),
        .op_code_i         (op_code_i),
        .op_code_valid_i   (op_code_valid_i),
        .operand_valid_i   (operand_valid_i),
        .operand_index_i   (operand_index_i),
        .response_o        (response_o),
        .response_valid_o  (response_valid_o)
    );

    always #50 clock_byte = ~clock_byte;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic random_pixel(output pixel_raw_t value);
        int b;
        value = '0;
        for (b = 0; b < $bits(pixel_raw_t); b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[$bits(pixel_raw_t)-2:0], lfsr_state[0]};   // One step per bit
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clock_byte);
    endtask

    task automatic flag_error(input string what);
        $display("error at %0t: %s", $time, what);
        error_count++;
    endtask

    task automatic compare_byte(input string name, input pixel_byte_t expected,
                                input pixel_byte_t actual);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected 0x%02h, got 0x%02h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_at_test_start = error_count;
        test_count++;
    endtask

    task automatic finish_test();
        if (error_count == errors_at_test_start) begin
            $display("test %0d %s: passed", test_count, test_name);
        end else begin
            $display("test %0d %s: failed with %0d errors", test_count, test_name,
                     error_count - errors_at_test_start);
            failed_tests++;
        end
    endtask

    // One frame of 14 lines by 28 pixels, optionally with a capture command mid frame
    task automatic send_frame(input bit capture_mid_frame);
        int line;
        int col;
        pixel_raw_t pixel;
        frame_valid_i = 1'b1;
        wait_cycles(2);
        for (line = 0; line < FRAME_LINES; line++) begin
            line_valid_i = 1'b1;
            for (col = 0; col < LINE_PIXELS; col++) begin
                random_pixel(pixel);
                pixel_data_i = pixel;
                if (line >= WINDOW_Y_OFFSET && line < WINDOW_Y_OFFSET + WINDOW_Y_SIZE
                    && col >= WINDOW_X_OFFSET && col < WINDOW_X_OFFSET + WINDOW_X_SIZE) begin
                    frame_model[(line - WINDOW_Y_OFFSET) * WINDOW_X_SIZE
                                + (col - WINDOW_X_OFFSET)] = pixel[9:2];
                end
                if (capture_mid_frame && line == 5) begin
                    if (col == 0) begin
                        op_code_i       = OP_CAPTURE;
                        op_code_valid_i = 1'b1;
                    end else if (col == 4) begin
                        op_code_valid_i = 1'b0;
                    end
                end
                @(negedge clock_byte);
            end
            line_valid_i = 1'b0;
            pixel_data_i = '0;
            wait_cycles(LINE_GAP);
        end
        frame_valid_i = 1'b0;
        wait_cycles(4);   // Let the last writes land
    endtask

    task automatic send_capture();
        op_code_i       = OP_CAPTURE;
        op_code_valid_i = 1'b1;
        wait_cycles(2);
        op_code_valid_i = 1'b0;
        wait_cycles(2);
    endtask

    task automatic check_bytes_available(input byte_count_t expected);
        op_code_i       = OP_BYTES_AVAILABLE;
        op_code_valid_i = 1'b1;
        operand_index_i = 8'd0;
        operand_valid_i = 1'b1;
        wait_cycles(1);
        operand_valid_i = 1'b0;
        wait_cycles(3);
        if (response_valid_o !== 1'b1) begin
            flag_error("response_valid_o is not high during a bytes available command");
        end
        compare_byte("response_o (bytes available, high)", expected[15:8], response_o);
        operand_index_i = 8'd1;
        operand_valid_i = 1'b1;
        wait_cycles(1);
        operand_valid_i = 1'b0;
        wait_cycles(3);
        compare_byte("response_o (bytes available, low)", expected[7:0], response_o);
        op_code_valid_i = 1'b0;
        operand_index_i = 8'd0;
        wait_cycles(1);
    endtask

    // Reads the whole buffer, leaving the read pointer at the end
    task automatic read_buffer();
        int i;
        op_code_i       = OP_READ_DATA;
        op_code_valid_i = 1'b1;
        wait_cycles(4);
        for (i = 0; i < CAPTURE_BYTES; i++) begin
            compare_byte($sformatf("response_o (byte %0d)", i), buffer_model[i], response_o);
            operand_valid_i = 1'b1;
            wait_cycles(1);
            operand_valid_i = 1'b0;
            wait_cycles(3);
        end
        op_code_valid_i = 1'b0;
        wait_cycles(1);
    endtask

    task automatic check_unknown_opcode();
        op_code_i       = 8'h5a;
        op_code_valid_i = 1'b1;
        wait_cycles(2);
        if (response_valid_o !== 1'b0) begin
            flag_error("response_valid_o is high for an unknown op-code");
        end
        op_code_valid_i = 1'b0;
        wait_cycles(1);
        op_code_i       = OP_BYTES_AVAILABLE;
        op_code_valid_i = 1'b1;
        wait_cycles(1);
        if (response_valid_o !== 1'b1) begin
            flag_error("response_valid_o did not rise the cycle after a known op-code");
        end
        op_code_valid_i = 1'b0;
        wait_cycles(1);
        if (response_valid_o !== 1'b0) begin
            flag_error("response_valid_o did not fall the cycle after op_code_valid_i fell");
        end
        wait_cycles(1);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock_byte);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        reset_sync_n    = 1'b0;
        frame_valid_i   = 1'b0;
        line_valid_i    = 1'b0;
        pixel_data_i    = '0;
        op_code_i       = '0;
        op_code_valid_i = 1'b0;
        operand_valid_i = 1'b0;
        operand_index_i = 8'd0;
        lfsr_state      = 32'h01f1_9a1f;
        error_count     = 0;
        test_count      = 0;
        failed_tests    = 0;
        wait_cycles(8);
        reset_sync_n = 1'b1;
        wait_cycles(2);

        start_test("state after reset");
        if (response_valid_o !== 1'b0) begin
            flag_error("response_valid_o is not low after reset");
        end
        check_bytes_available(16'd0);
        finish_test();

        start_test("capture one frame");
        send_capture();
        send_frame(1'b0);
        buffer_model = frame_model;
        check_bytes_available(byte_count_t'(CAPTURE_BYTES));
        finish_test();

        start_test("read the captured window");
        read_buffer();
        check_bytes_available(16'd0);
        finish_test();

        start_test("frame without capture");
        send_frame(1'b0);
        check_bytes_available(16'd0);
        send_capture();                     // Rewinds the pointer over the old data
        check_bytes_available(byte_count_t'(CAPTURE_BYTES));
        read_buffer();
        check_bytes_available(16'd0);
        finish_test();

        start_test("capture command during a capture");
        send_frame(1'b1);                   // Still armed from the previous test
        buffer_model = frame_model;
        check_bytes_available(16'd0);       // Pointer still at the end of the buffer
        send_capture();
        check_bytes_available(byte_count_t'(CAPTURE_BYTES));
        read_buffer();
        check_bytes_available(16'd0);
        finish_test();

        start_test("unknown op-code and response_valid_o timing");
        check_unknown_opcode();
        finish_test();

        $display("%0d tests run, %0d failed, %0d errors in total",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: camera_sva.sv
`default_nettype none

module camera_sva import camera_pkg::*; (
    input wire                                 clock_byte,
    input wire                                 reset_sync_n,
    input wire [$bits(capture_state_t)-1:0]    state_i,
    input wire [BANK_COUNT-1:0]                bank_write_en_i,
    input wire byte_count_t                    captured_count_i
);

    // Enables are registered, so look one cycle back
    enable_in_active: assert property (@(posedge clock_byte) disable iff (!reset_sync_n)
        (|bank_write_en_i) |-> ($past(state_i) == CAPTURE_ACTIVE))
        else $error("bank write enable high outside a capture");

    single_bank: assert property (@(posedge clock_byte) disable iff (!reset_sync_n)
        $onehot0(bank_write_en_i))
        else $error("more than one bank write enable high");

    count_in_range: assert property (@(posedge clock_byte) disable iff (!reset_sync_n)
        captured_count_i <= byte_count_t'(CAPTURE_BYTES))
        else $error("captured count above the buffer size");

endmodule

bind pixel_window camera_sva u_camera_sva (
    .clock_byte        (clock_byte),
    .reset_sync_n      (reset_sync_n),
    .state_i           (state_q),
    .bank_write_en_i   (bank_write_en_o),
    .captured_count_i  (captured_count_o)
);

`default_nettype wire

// File: camera_top.sv
`default_nettype none

module camera_top import camera_pkg::*; (
    input  wire               clock_byte,
    input  wire               reset_sync_n,

    // Sensor stream
    input  wire               frame_valid_i,
    input  wire               line_valid_i,
    input  wire pixel_raw_t   pixel_data_i,

    // Host commands
    input  wire op_code_t     op_code_i,
    input  wire               op_code_valid_i,
    input  wire               operand_valid_i,
    input  wire [7:0]         operand_index_i,
    output pixel_byte_t       response_o,
    output logic              response_valid_o
);

    logic [BANK_COUNT-1:0]         bank_write_en;
    bank_addr_t                    bank_write_addr;
    pixel_byte_t                   bank_write_data;
    bank_addr_t                    bank_read_addr;
    pixel_byte_t [BANK_COUNT-1:0]  bank_read_data;
    byte_count_t                   captured_count;
    logic                          capture_busy;
    logic                          capture_request;

    pixel_window u_pixel_window (
        .clock_byte         (clock_byte),
        .reset_sync_n       (reset_sync_n),
        .frame_valid_i      (frame_valid_i),
        .line_valid_i       (line_valid_i),
        .pixel_data_i       (pixel_data_i),
        .capture_request_i  (capture_request),
        .bank_write_en_o    (bank_write_en),
        .bank_write_addr_o  (bank_write_addr),
        .bank_write_data_o  (bank_write_data),
        .captured_count_o   (captured_count),
        .capture_busy_o     (capture_busy)
    );

    // Write side shared, each bank picks up its own enable
    for (genvar i = 0; i < BANK_COUNT; i++) begin : gen_bank
        buffer_bank u_bank (
            .clock_byte    (clock_byte),
            .write_en_i    (bank_write_en[i]),
            .write_addr_i  (bank_write_addr),
            .write_data_i  (bank_write_data),
            .read_addr_i   (bank_read_addr),
            .read_data_o   (bank_read_data[i])
        );
    end

    command_port u_command_port (
        .clock_byte         (clock_byte),
        .reset_sync_n       (reset_sync_n),
        .op_code_i          (op_code_i),
        .op_code_valid_i    (op_code_valid_i),
        .operand_valid_i    (operand_valid_i),
        .operand_index_i    (operand_index_i),
        .captured_count_i   (captured_count),
        .capture_busy_i     (capture_busy),
        .bank_read_data_i   (bank_read_data),
        .capture_request_o  (capture_request),
        .bank_read_addr_o   (bank_read_addr),
        .response_o         (response_o),
        .response_valid_o   (response_valid_o)
    );

endmodule

`default_nettype wire

// File: command_port.sv
`default_nettype none

module command_port import camera_pkg::*; (
    input  wire                               clock_byte,
    input  wire                               reset_sync_n,
    input  wire op_code_t                     op_code_i,
    input  wire                               op_code_valid_i,
    input  wire                               operand_valid_i,
    input  wire [7:0]                         operand_index_i,
    input  wire byte_count_t                  captured_count_i,
    input  wire                               capture_busy_i,
    input  wire pixel_byte_t [BANK_COUNT-1:0] bank_read_data_i,
    output logic                              capture_request_o,
    output bank_addr_t                        bank_read_addr_o,
    output pixel_byte_t                       response_o,
    output logic                              response_valid_o
);

    logic         op_code_valid_q;
    logic         operand_valid_q;
    logic         op_code_rise;
    logic         operand_rise;
    byte_count_t  read_ptr_q;
    byte_count_t  bytes_remaining;
    buffer_addr_t read_addr;
    bank_sel_t    read_bank_q;
    pixel_byte_t  read_byte;

    assign op_code_rise = op_code_valid_i && !op_code_valid_q;
    assign operand_rise = operand_valid_i && !operand_valid_q;

    assign bytes_remaining = captured_count_i - read_ptr_q;

    // Pointer is wider than the buffer so the count can reach zero
    assign read_addr        = buffer_addr_t'(read_ptr_q);
    assign bank_read_addr_o = read_addr[$bits(buffer_addr_t)-1:$bits(bank_sel_t)];

    // Bank data arrives a cycle after the address, so use the delayed select
    assign read_byte = bank_read_data_i[read_bank_q];

    always_ff @(posedge clock_byte or negedge reset_sync_n) begin
        if (!reset_sync_n) begin
            op_code_valid_q   <= 1'b0;
            operand_valid_q   <= 1'b0;
            read_ptr_q        <= '0;
            read_bank_q       <= '0;
            capture_request_o <= 1'b0;
            response_valid_o  <= 1'b0;
        end else begin
            op_code_valid_q   <= op_code_valid_i;
            operand_valid_q   <= operand_valid_i;
            read_bank_q       <= read_addr[$bits(bank_sel_t)-1:0];
            capture_request_o <= 1'b0;

            if (op_code_valid_i) begin
                case (op_code_i)
                    OP_CAPTURE: begin
                        response_valid_o <= 1'b1;
                        // Only once per command, and never mid capture
                        if (op_code_rise && !capture_busy_i) begin
                            capture_request_o <= 1'b1;
                            read_ptr_q        <= '0;
                        end
                    end
                    OP_BYTES_AVAILABLE: begin
                        response_valid_o <= 1'b1;
                    end
                    OP_READ_DATA: begin
                        response_valid_o <= 1'b1;
                        if (operand_rise) begin
                            read_ptr_q <= read_ptr_q + 1'b1;
                        end
                    end
                    default: begin
                        response_valid_o <= 1'b0;   // Unknown op-code
                    end
                endcase
            end else begin
                response_valid_o <= 1'b0;
            end
        end
    end

    // Response byte
    always_ff @(posedge clock_byte) begin
        if (op_code_valid_i) begin
            case (op_code_i)
                OP_CAPTURE: begin
                    response_o <= {7'd0, capture_busy_i};   // Status, bit 0 is busy
                end
                OP_BYTES_AVAILABLE: begin
                    if (operand_index_i == 8'd0) begin
                        response_o <= bytes_remaining[15:8];
                    end else if (operand_index_i == 8'd1) begin
                        response_o <= bytes_remaining[7:0];
                    end
                end
                OP_READ_DATA: begin
                    response_o <= read_byte;
                end
                default: begin
                    response_o <= response_o;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: buffer_bank.sv
`default_nettype none

module buffer_bank import camera_pkg::*; (
    input  wire               clock_byte,
    input  wire               write_en_i,
    input  wire bank_addr_t   write_addr_i,
    input  wire pixel_byte_t  write_data_i,
    input  wire bank_addr_t   read_addr_i,
    output pixel_byte_t       read_data_o
);

    // Plain dual-port array, infers block RAM
    pixel_byte_t mem [BANK_DEPTH];

    always_ff @(posedge clock_byte) begin
        if (write_en_i) begin
            mem[write_addr_i] <= write_data_i;
        end
    end

    // Registered read, one cycle of latency
    always_ff @(posedge clock_byte) begin
        read_data_o <= mem[read_addr_i];
    end

endmodule

`default_nettype wire

// File: pixel_window.sv
`default_nettype none

module pixel_window import camera_pkg::*; (
    input  wire                     clock_byte,
    input  wire                     reset_sync_n,
    input  wire                     frame_valid_i,
    input  wire                     line_valid_i,
    input  wire pixel_raw_t         pixel_data_i,
    input  wire                     capture_request_i,
    output logic [BANK_COUNT-1:0]   bank_write_en_o,
    output bank_addr_t              bank_write_addr_o,
    output pixel_byte_t             bank_write_data_o,
    output byte_count_t             captured_count_o,
    output logic                    capture_busy_o
);

    column_t        column_q;
    line_t          line_q;
    logic           frame_valid_q;
    logic           line_valid_q;
    logic           frame_rise;
    logic           frame_fall;
    logic           line_fall;
    logic           in_window;
    logic           write_pixel;
    capture_state_t state_q;
    byte_count_t    count_q;
    buffer_addr_t   byte_addr;
    bank_sel_t      byte_bank;

    assign frame_rise = frame_valid_i && !frame_valid_q;
    assign frame_fall = !frame_valid_i && frame_valid_q;
    assign line_fall  = !line_valid_i && line_valid_q;

    // Window test on the current pixel position
    assign in_window = line_valid_i
        && (column_q >= column_t'(WINDOW_X_OFFSET))
        && (column_q <  column_t'(WINDOW_X_OFFSET + WINDOW_X_SIZE))
        && (line_q   >= line_t'(WINDOW_Y_OFFSET))
        && (line_q   <  line_t'(WINDOW_Y_OFFSET + WINDOW_Y_SIZE));

    assign write_pixel = (state_q == CAPTURE_ACTIVE) && in_window;

    // Byte n lands in bank n mod 4 at address n / 4
    assign byte_addr = buffer_addr_t'(count_q);
    assign byte_bank = byte_addr[$bits(bank_sel_t)-1:0];

    // Position counters follow the sensor qualifiers
    always_ff @(posedge clock_byte or negedge reset_sync_n) begin
        if (!reset_sync_n) begin
            frame_valid_q <= 1'b0;
            line_valid_q  <= 1'b0;
            column_q      <= '0;
            line_q        <= '0;
        end else begin
            frame_valid_q <= frame_valid_i;
            line_valid_q  <= line_valid_i;

            if (line_valid_i) begin
                if (column_q != '1) begin   // Saturate on oversized lines
                    column_q <= column_q + 1'b1;
                end
            end else begin
                column_q <= '0;
            end

            if (!frame_valid_i) begin
                line_q <= '0;
            end else if (line_fall && line_q != '1) begin
                line_q <= line_q + 1'b1;
            end
        end
    end

    // Capture FSM and byte counter
    always_ff @(posedge clock_byte or negedge reset_sync_n) begin
        if (!reset_sync_n) begin
            state_q <= CAPTURE_IDLE;
            count_q <= '0;
        end else begin
            case (state_q)
                CAPTURE_IDLE: begin
                    if (capture_request_i) begin
                        state_q <= CAPTURE_ARMED;
                    end
                end
                CAPTURE_ARMED: begin
                    if (frame_rise) begin
                        state_q <= CAPTURE_ACTIVE;
                        count_q <= '0;      // Old frame is discarded here
                    end
                end
                CAPTURE_ACTIVE: begin
                    if (frame_fall) begin
                        state_q <= CAPTURE_IDLE;
                    end
                    if (write_pixel) begin
                        count_q <= count_q + 1'b1;
                    end
                end
                default: state_q <= CAPTURE_IDLE;
            endcase
        end
    end

    // One bank enable per written byte
    always_ff @(posedge clock_byte or negedge reset_sync_n) begin
        if (!reset_sync_n) begin
            bank_write_en_o <= '0;
        end else begin
            bank_write_en_o <= '0;
            if (write_pixel) begin
                bank_write_en_o[byte_bank] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock_byte) begin
        if (write_pixel) begin
            bank_write_addr_o <= byte_addr[$bits(buffer_addr_t)-1:$bits(bank_sel_t)];
            // Keep the top 8 of the 10 bits
            bank_write_data_o <= pixel_data_i[$bits(pixel_raw_t)-1 -: $bits(pixel_byte_t)];
        end
    end

    assign captured_count_o = count_q;
    assign capture_busy_o   = (state_q != CAPTURE_IDLE);

endmodule

`default_nettype wire

// File: camera_pkg.sv
`default_nettype none

package camera_pkg;

    // Crop window, in sensor pixels
    localparam int WINDOW_X_OFFSET = 4;
    localparam int WINDOW_Y_OFFSET = 2;
    localparam int WINDOW_X_SIZE   = 16;
    localparam int WINDOW_Y_SIZE   = 8;
    localparam int CAPTURE_BYTES   = WINDOW_X_SIZE * WINDOW_Y_SIZE;

    // Image buffer is interleaved byte by byte across the banks
    localparam int BANK_COUNT = 4;
    localparam int BANK_DEPTH = CAPTURE_BYTES / BANK_COUNT;

    // Host command set
    localparam logic [7:0] OP_CAPTURE         = 8'h20;
    localparam logic [7:0] OP_BYTES_AVAILABLE = 8'h21;
    localparam logic [7:0] OP_READ_DATA       = 8'h22;

    // RAW10 from the sensor
    typedef logic [9:0] pixel_raw_t;

    // What ends up in the buffer
    typedef logic [7:0] pixel_byte_t;

    // Byte address over the whole buffer
    typedef logic [$clog2(CAPTURE_BYTES)-1:0] buffer_addr_t;

    // Low bits of a buffer address
    typedef logic [$clog2(BANK_COUNT)-1:0] bank_sel_t;

    // High bits of a buffer address
    typedef logic [$clog2(BANK_DEPTH)-1:0] bank_addr_t;

    typedef logic [15:0] byte_count_t;    // As seen by the host
    typedef logic [7:0]  op_code_t;

    // Positions inside the incoming frame
    typedef logic [7:0] column_t;
    typedef logic [7:0] line_t;

    typedef enum logic [1:0] {
        CAPTURE_IDLE,
        CAPTURE_ARMED,     // Waiting for the next frame start
        CAPTURE_ACTIVE
    } capture_state_t;

endpackage

`default_nettype wire
